/* include/gf_ops.svh */
// ==========================================================================
// gf(2^8) arithmetic for the aes column mix
// xtime, multiply by a small constant and forward and inverse column mix
// ==========================================================================

`ifndef GF_OPS_SVH
`define GF_OPS_SVH

// multiply by x, reduce with the aes polynomial 0x11b
function automatic logic [7:0] gf_xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

// multiply a byte by a constant of up to 4 bits with shift and add
function automatic logic [7:0] gf_mul(input logic [7:0] b, input logic [3:0] c);
    logic [7:0] acc;
    logic [7:0] pow;
    acc = 8'h00;
    pow = b;
    for (int k = 0; k < 4; k++)
    begin
        if (c[k])
            acc = acc ^ pow;
        pow = gf_xtime(pow);
    end
    return acc;
endfunction

// forward mix of one column, row i uses 2 3 1 1 rotated by i
function automatic word_t col_mix(input word_t w);
    word_t r;
    for (int i = 0; i < WORD_BYTES; i++)
    begin
        r[i] = gf_mul(w[i], 4'd2) ^ gf_mul(w[(i+1)%WORD_BYTES], 4'd3)
             ^ w[(i+2)%WORD_BYTES] ^ w[(i+3)%WORD_BYTES];
    end
    return r;
endfunction

// inverse mix of one column, coefficients 14 11 13 9 rotated by row
function automatic word_t col_inv_mix(input word_t w);
    word_t r;
    for (int i = 0; i < WORD_BYTES; i++)
    begin
        r[i] = gf_mul(w[i], 4'd14) ^ gf_mul(w[(i+1)%WORD_BYTES], 4'd11)
             ^ gf_mul(w[(i+2)%WORD_BYTES], 4'd13) ^ gf_mul(w[(i+3)%WORD_BYTES], 4'd9);
    end
    return r;
endfunction

`endif

/* logic/mix_col_pkg.sv */
// ==========================================================================
// mix column package
// shared widths, column and state types, the operation encoding and the
// block struct passed from the gather stage into the mixer
// ==========================================================================

package mix_col_pkg;

    // bytes in one column word
    localparam int WORD_BYTES = 4;
    // column words in one aes state
    localparam int STATE_WORDS = 4;

    // one column, byte 0 is row 0 and sits in the low 8 bits
    typedef logic [WORD_BYTES-1:0][7:0] word_t;

    // full state, index j holds column j
    typedef word_t [STATE_WORDS-1:0] state_t;

    // round key uses the same column layout as the state
    typedef word_t [STATE_WORDS-1:0] key_t;

    // operation applied to every column of a block
    typedef enum logic [1:0] {
        OP_MIX     = 2'd0,
        OP_INV_MIX = 2'd1,
        OP_MIX_KEY = 2'd2,
        OP_KEY     = 2'd3
    } mix_op_e;

    // gathered block with its operation and key, 258 bits
    typedef struct packed {
        mix_op_e op;
        key_t    key;
        state_t  state;
    } mix_blk_t;

    // gf(2^8) helpers and the single column mix functions
    `include "gf_ops.svh"

endpackage

/* logic/column_gather.sv */
// ==========================================================================
// column gather
// collects four consecutive column words into one aes state and tags the
// finished block with its operation and round key
// ==========================================================================

`timescale 1ns/1ps

module column_gather (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 restart,
    input  logic                 in_valid,
    input  mix_col_pkg::word_t   in_word,
    input  mix_col_pkg::mix_op_e in_op,
    input  mix_col_pkg::key_t    in_key,
    output logic                 gath_valid,
    output mix_col_pkg::mix_blk_t gath_blk
);

    import mix_col_pkg::*;

    // slot of the next accepted word
    logic [1:0] wr_cnt;
    // columns collected so far for the current block
    state_t     state_q;
    // state with the incoming word dropped into its slot
    state_t     next_state;
    logic       accept;
    logic       last_word;

    // restart has priority so a word on the same edge is dropped
    assign accept    = in_valid && !restart;
    assign last_word = accept && (wr_cnt == 2'(STATE_WORDS - 1));

    always_comb
    begin
        next_state         = state_q;
        next_state[wr_cnt] = in_word;
    end

    // word counter and block strobe
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_cnt     <= 2'd0;
            gath_valid <= 1'b0;
        end
        else
        begin
            gath_valid <= last_word;
            if (restart)
                // partial block is thrown away
                wr_cnt <= 2'd0;
            else if (accept)
                // wraps to zero after the fourth word
                wr_cnt <= wr_cnt + 2'd1;
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (accept)
            state_q <= next_state;
        if (last_word)
        begin
            // op and key are only read with the closing word
            gath_blk.op    <= in_op;
            gath_blk.key   <= in_key;
            gath_blk.state <= next_state;
        end
    end

endmodule

/* logic/column_mixer.sv */
// ==========================================================================
// column mixer
// one registered stage applying the selected operation to all four columns
// forward mix, inverse mix, forward mix plus round key, or round key only
// ==========================================================================

`timescale 1ns/1ps

module column_mixer (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  gath_valid,
    input  mix_col_pkg::mix_blk_t gath_blk,
    output logic                  mix_valid,
    output mix_col_pkg::state_t   mix_state
);

    import mix_col_pkg::*;

    // combinational result for the whole state
    state_t result;

    // one identical slice per column
    for (genvar j = 0; j < STATE_WORDS; j++)
    begin : g_col
        word_t fwd_col;
        word_t inv_col;
        word_t key_col;
        word_t in_col;

        assign in_col  = gath_blk.state[j];
        // key column j pairs with state column j
        assign key_col = gath_blk.key[j];
        assign fwd_col = col_mix(in_col);
        assign inv_col = col_inv_mix(in_col);

        always_comb
        begin
            unique case (gath_blk.op)
                OP_MIX:
                begin
                    result[j] = fwd_col;
                end
                OP_INV_MIX:
                begin
                    result[j] = inv_col;
                end
                OP_MIX_KEY:
                begin
                    // mix first then add the round key
                    result[j] = fwd_col ^ key_col;
                end
                OP_KEY:
                begin
                    result[j] = in_col ^ key_col;
                end
                default:
                begin
                    result[j] = in_col;
                end
            endcase
        end
    end

    // valid follows gath_valid by one cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            mix_valid <= 1'b0;
        else
            mix_valid <= gath_valid;
    end

    // result register, only loaded with a block
    always_ff @(posedge clk)
    begin
        if (gath_valid)
            mix_state <= result;
    end

endmodule

/* logic/column_scatter.sv */
// ==========================================================================
// column scatter
// holds a finished state and sends it out as four column words on
// consecutive cycles with the column number alongside
// ==========================================================================

`timescale 1ns/1ps

module column_scatter (
    input  logic                clk,
    input  logic                resetn,
    input  logic                mix_valid,
    input  mix_col_pkg::state_t mix_state,
    output logic                out_valid,
    output mix_col_pkg::word_t  out_word,
    output logic [1:0]          out_index
);

    import mix_col_pkg::*;

    // block being sent out
    state_t     hold_q;
    // column currently on the output
    logic [1:0] rd_cnt;
    logic       busy;

    // control, a new block may land in the last busy cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy   <= 1'b0;
            rd_cnt <= 2'd0;
        end
        else if (mix_valid)
        begin
            busy   <= 1'b1;
            rd_cnt <= 2'd0;
        end
        else if (busy)
        begin
            rd_cnt <= rd_cnt + 2'd1;
            // done after column 3
            if (rd_cnt == 2'(STATE_WORDS - 1))
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (mix_valid)
            hold_q <= mix_state;
    end

    // outputs come straight from the registers
    assign out_valid = busy;
    assign out_word  = hold_q[rd_cnt];
    assign out_index = rd_cnt;

endmodule

/* logic/mix_col_top.sv */
// ==========================================================================
// mix column top level
// gather, mixer and scatter in a chain, one word in and one word out
// ==========================================================================

`timescale 1ns/1ps

module mix_col_top (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 restart,
    input  logic                 in_valid,
    input  mix_col_pkg::word_t   in_word,
    input  mix_col_pkg::mix_op_e in_op,
    input  mix_col_pkg::key_t    in_key,
    output logic                 out_valid,
    output mix_col_pkg::word_t   out_word,
    output logic [1:0]           out_index
);

    import mix_col_pkg::*;

    // gather to mixer
    logic     gath_valid;
    mix_blk_t gath_blk;
    // mixer to scatter
    logic     mix_valid;
    state_t   mix_state;

    column_gather u_gather (
        .clk        (clk),
        .resetn     (resetn),
        .restart    (restart),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_op      (in_op),
        .in_key     (in_key),
        .gath_valid (gath_valid),
        .gath_blk   (gath_blk)
    );

    column_mixer u_mixer (
        .clk        (clk),
        .resetn     (resetn),
        .gath_valid (gath_valid),
        .gath_blk   (gath_blk),
        .mix_valid  (mix_valid),
        .mix_state  (mix_state)
    );

    column_scatter u_scatter (
        .clk       (clk),
        .resetn    (resetn),
        .mix_valid (mix_valid),
        .mix_state (mix_state),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_index (out_index)
    );

endmodule

/* test/mix_col_checker.sv */
// ==========================================================================
// column scatter checker
// concurrent assertions on the output framing of the scatter stage
// bound into every column_scatter instance
// ==========================================================================

`timescale 1ns/1ps

module mix_col_checker (
    input  logic       clk,
    input  logic       resetn,
    input  logic       mix_valid,
    input  logic       busy,
    input  logic       out_valid,
    input  logic [1:0] out_index
);

    // count of failed assertions
    int fail_count = 0;

    // every block starts on column 0
    a_start_col0: assert property (@(posedge clk) disable iff (!resetn)
        $rose(out_valid) |-> out_index == 2'd0)
        else
        begin
            $error("output block did not start at column 0");
            fail_count++;
        end

    // columns 0 to 2 are followed by the next column with valid held high
    a_col_step: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && out_index != 2'd3 |=> out_valid && out_index == $past(out_index) + 2'd1)
        else
        begin
            $error("output columns not on consecutive cycles in order");
            fail_count++;
        end

    // after column 3 the output goes idle unless a new block was loaded
    a_block_end: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && out_index == 2'd3 && !mix_valid |=> !out_valid)
        else
        begin
            $error("output block longer than four columns");
            fail_count++;
        end

    // a new block may only land in the last busy cycle
    a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
        mix_valid && busy |-> out_index == 2'd3)
        else
        begin
            $error("mixer result arrived while the scatter was busy");
            fail_count++;
        end

    // no output while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !resetn |-> !out_valid)
        else
        begin
            $error("out_valid high during reset");
            fail_count++;
        end

endmodule

bind column_scatter mix_col_checker u_chk (
    .clk       (clk),
    .resetn    (resetn),
    .mix_valid (mix_valid),
    .busy      (busy),
    .out_valid (out_valid),
    .out_index (out_index)
);

/* test/mix_col_monitor.sv */
// ==========================================================================
// mix column output monitor
// holds the expected column words, compares every output word with the
// oldest one, checks value, column index and cycle, and counts errors
// ==========================================================================

`timescale 1ns/1ps

module mix_col_monitor (
    input  logic                clk,
    input  int                  cycle,
    input  logic                out_valid,
    input  mix_col_pkg::word_t  out_word,
    input  logic [1:0]          out_index,
    input  logic                exp_push,
    input  mix_col_pkg::state_t exp_state,
    input  int                  exp_due,
    output int                  pending,
    output int                  error_count
);

    import mix_col_pkg::*;

    // one expected output word with its column and due cycle
    typedef struct packed {
        word_t      word;
        logic [1:0] index;
        int         due;
    } exp_entry_t;

    // oldest expected word at the front
    exp_entry_t exp_q[$];

    initial
    begin
        pending     = 0;
        error_count = 0;
    end

    // compare one output word with its expected entry
    task automatic check_output(input exp_entry_t head);
        if (out_word !== head.word)
        begin
            $display("FAILED at %0t: column %0d expected %h got %h",
                     $time, head.index, head.word, out_word);
            error_count++;
        end
        if (out_index !== head.index)
        begin
            $display("FAILED at %0t: column index expected %0d got %0d",
                     $time, head.index, out_index);
            error_count++;
        end
        // first word 3 cycles after the last input, then one per cycle
        if (cycle != head.due)
        begin
            $display("ERROR at %0t: column %0d came out in cycle %0d but was due in cycle %0d",
                     $time, head.index, cycle, head.due);
            error_count++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        exp_entry_t head;
        exp_entry_t entry;
        if (out_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("ERROR at %0t: unexpected output %h on column %0d with nothing pending",
                         $time, out_word, out_index);
                error_count++;
            end
            else
            begin
                head = exp_q.pop_front();
                check_output(head);
            end
        end
        else if (exp_q.size() != 0 && exp_q[0].due <= cycle)
        begin
            // the word should have been out by now
            head = exp_q.pop_front();
            $display("ERROR at %0t: column %0d due in cycle %0d never came out",
                     $time, head.index, head.due);
            error_count++;
        end
        // new block from the stimulus, all four columns at once
        if (exp_push)
        begin
            for (int j = 0; j < STATE_WORDS; j++)
            begin
                entry.word  = exp_state[j];
                entry.index = 2'(j);
                entry.due   = exp_due + j;
                exp_q.push_back(entry);
            end
        end
        pending = exp_q.size();
    end

endmodule

/* test/mix_col_tb.sv */
// ==========================================================================
// mix column testbench
// seeded random blocks for every operation, directed inverse round trips,
// restart and long back to back runs, checked by the output monitor
// ==========================================================================

`timescale 1ns/1ps

module mix_col_tb;

    import mix_col_pkg::*;

    localparam int unsigned SEED = 32'hfa63_a229;
    localparam int RESET_CYCLES    = 3;
    localparam int OP_BLOCKS       = 8;
    localparam int RAND_BLOCKS     = 120;
    localparam int ROUNDTRIP_PAIRS = 8;
    localparam int STREAM_BLOCKS   = 40;
    // worst case with every random gap at 3 idle cycles
    localparam int STIM_CYCLES = RESET_CYCLES + 2 + (4 * OP_BLOCKS + RAND_BLOCKS) * 7
                               + ROUNDTRIP_PAIRS * 9 + 24 + STREAM_BLOCKS * 4;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 50;

    logic       clk;
    logic       resetn;
    logic       restart;
    logic       in_valid;
    word_t      in_word;
    mix_op_e    in_op;
    key_t       in_key;
    logic       out_valid;
    word_t      out_word;
    logic [1:0] out_index;

    // expected block handed to the monitor
    logic   exp_push;
    state_t exp_state;
    int     exp_due;
    int     pending;
    int     mon_errors;

    int          cycle_cnt = 0;
    int unsigned seed_ret;
    int          total_errors;

    mix_col_top UUT (
        .clk       (clk),
        .resetn    (resetn),
        .restart   (restart),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_op     (in_op),
        .in_key    (in_key),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_index (out_index)
    );

    mix_col_monitor u_monitor (
        .clk         (clk),
        .cycle       (cycle_cnt),
        .out_valid   (out_valid),
        .out_word    (out_word),
        .out_index   (out_index),
        .exp_push    (exp_push),
        .exp_state   (exp_state),
        .exp_due     (exp_due),
        .pending     (pending),
        .error_count (mon_errors)
    );

    initial
        clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // run limit from the worst case stimulus length
    always @(posedge clk)
    begin
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, %0d words still pending, %0d errors",
                     cycle_cnt, pending, mon_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    // reference model, column j of state and key go together
    function automatic state_t model_block(input mix_op_e op, input state_t s, input key_t k);
        state_t r;
        for (int j = 0; j < STATE_WORDS; j++)
        begin
            case (op)
                OP_MIX:     r[j] = col_mix(s[j]);
                OP_INV_MIX: r[j] = col_inv_mix(s[j]);
                OP_MIX_KEY: r[j] = col_mix(s[j]) ^ k[j];
                default:    r[j] = s[j] ^ k[j];
            endcase
        end
        return r;
    endfunction

    function automatic state_t random_state();
        state_t s;
        for (int j = 0; j < STATE_WORDS; j++)
            s[j] = $urandom;
        return s;
    endfunction

    function automatic mix_op_e random_op();
        return mix_op_e'(2'($urandom_range(0, 3)));
    endfunction

    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            next_cycle();
            restart  = 1'b0;
            in_valid = 1'b0;
            exp_push = 1'b0;
            in_word  = $urandom;
        end
    endtask

    // four words, op and key only valid with the last one
    task automatic send_block(input state_t words, input mix_op_e op, input key_t key,
                              input state_t expect_state);
        for (int j = 0; j < STATE_WORDS; j++)
        begin
            next_cycle();
            restart  = 1'b0;
            in_valid = 1'b1;
            in_word  = words[j];
            if (j == STATE_WORDS - 1)
            begin
                in_op     = op;
                in_key    = key;
                exp_push  = 1'b1;
                exp_state = expect_state;
                exp_due   = cycle_cnt + 3;
            end
            else
            begin
                // junk that the gather stage must ignore
                in_op    = random_op();
                in_key   = random_state();
                exp_push = 1'b0;
            end
        end
    endtask

    task automatic send_random_block(input mix_op_e op, input int max_gap);
        state_t words;
        key_t   key;
        words = random_state();
        key   = random_state();
        send_block(words, op, key, model_block(op, words, key));
        if (max_gap > 0)
            idle_cycles($urandom_range(0, max_gap));
    endtask

    // n words of a block, then a restart strobe
    task automatic send_partial(input int n, input bit drop_word);
        for (int j = 0; j < n; j++)
        begin
            next_cycle();
            exp_push = 1'b0;
            restart  = 1'b0;
            in_valid = 1'b1;
            in_word  = $urandom;
        end
        next_cycle();
        // a word on the restart edge is dropped too
        restart  = 1'b1;
        in_valid = drop_word;
        in_word  = $urandom;
    endtask

    initial
    begin
        state_t words;
        state_t mixed;
        key_t   key;
        seed_ret  = $urandom(SEED);
        resetn    = 1'b0;
        restart   = 1'b0;
        in_valid  = 1'b0;
        in_word   = '0;
        in_op     = OP_MIX;
        in_key    = '0;
        exp_push  = 1'b0;
        exp_state = '0;
        exp_due   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        resetn = 1'b1;
        idle_cycles(1);

        // each operation on its own
        for (int op = 0; op < 4; op++)
        begin
            for (int b = 0; b < OP_BLOCKS; b++)
                send_random_block(mix_op_e'(2'(op)), 3);
        end

        // forward mix fed back through the inverse gives the input again
        for (int p = 0; p < ROUNDTRIP_PAIRS; p++)
        begin
            words = random_state();
            key   = random_state();
            mixed = model_block(OP_MIX, words, key);
            send_block(words, OP_MIX, key, mixed);
            send_block(mixed, OP_INV_MIX, random_state(), words);
            idle_cycles(1);
        end

        // restart after 1 to 3 words, only the next block comes out
        for (int n = 1; n <= 3; n++)
        begin
            send_partial(n, n == 2);
            send_random_block(random_op(), 0);
            idle_cycles(1);
        end

        // mixed operations with random gaps
        for (int b = 0; b < RAND_BLOCKS; b++)
            send_random_block(random_op(), 3);

        // long back to back run at full rate
        for (int b = 0; b < STREAM_BLOCKS; b++)
            send_random_block(random_op(), 0);
        idle_cycles(1);

        // drain, then watch a while for stray outputs
        while (pending != 0)
            @(posedge clk);
        idle_cycles(8);

        total_errors = mon_errors + UUT.u_scatter.u_chk.fail_count;
        $display("closing report: %0d errors (%0d monitor, %0d assertion), %0d words pending",
                 total_errors, mon_errors, UUT.u_scatter.u_chk.fail_count, pending);
        if (total_errors == 0 && pending == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
logic/mix_col_pkg.sv
logic/column_gather.sv
logic/column_mixer.sv
logic/column_scatter.sv
logic/mix_col_top.sv
test/mix_col_checker.sv
test/mix_col_monitor.sv
test/mix_col_tb.sv

/* run.sh */
#!/bin/sh
# build the simulator from the file list, run it and keep the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module mix_col_tb \
    -o mix_col_sim \
    && ./obj_dir/mix_col_sim > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
# the run counts as passed only when the pass line is in the log
grep -q "TEST PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
